// ==== hw/aes192_pkg.sv ====
// Shared widths, round counts and pipeline latency of the AES-192 core.
// Key-step kind codes and the 128-bit state type seen as bytes or columns.

package aes192_pkg;

    localparam int BYTE_BITS = 8;
    localparam int WORD_BITS = 32;
    localparam int BLOCK_BITS = 128;
    localparam int KEY_BITS = 192;

    localparam int NUM_ROUNDS = 12; // Eleven middle rounds and one final round.
    localparam int ROUND_CYCLES = 2;
    localparam int PIPE_LATENCY = 1 + NUM_ROUNDS * ROUND_CYCLES;

    localparam logic [BYTE_BITS-1:0] GF_POLY_LOW = 8'h1b;

    // Which key words a schedule step renews.
    localparam int STEP_A = 0; // Words 0 to 3.
    localparam int STEP_B = 1; // Words 2 to 5, no SubWord.
    localparam int STEP_C = 2; // Words 4, 5, 0 and 1.
    localparam int STEP_D = 3; // Words 0 and 1.

    // Byte 0 and column 0 sit at the most significant end.
    typedef union packed {
        logic [0:15][BYTE_BITS-1:0] bytes;
        logic [0:3][WORD_BITS-1:0] cols;
    } state_t;

endpackage

// ==== hw/sbox.sv ====
// AES S-box for one byte as a Boyar-Peralta gate network.
// Linear input layer, shared GF(2^4) inversion, linear output layer, output register.

module sbox (
    input  logic                               clk,
    input  logic [aes192_pkg::BYTE_BITS-1:0]   in_byte,
    output logic [aes192_pkg::BYTE_BITS-1:0]   out_byte
);

    logic [0:7] x;
    logic [0:7] s;
    logic [21:1] y;
    logic [67:0] t;
    logic [0:8] inv;
    logic [0:17] z;

    assign x = in_byte; // Bit 0 is the most significant bit.

    always_comb
    begin
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9] = x[0] ^ x[3];
        y[8] = x[0] ^ x[5];
        t[0] = x[1] ^ x[2];
        y[1] = t[0] ^ x[7];
        y[4] = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2] = y[1] ^ x[0];
        y[5] = y[1] ^ x[6];
        y[3] = y[5] ^ y[8];
        t[1] = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6] = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7] = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        // Nonlinear core of the inversion.
        t[2] = y[12] & y[15];
        t[3] = y[3] & y[6];
        t[4] = t[3] ^ t[2];
        t[5] = y[4] & x[7];
        t[6] = t[5] ^ t[2];
        t[7] = y[13] & y[16];
        t[8] = y[5] & y[1];
        t[9] = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];

        // Both halves of the product layer share the same nine inversion outputs.
        inv = {t[44], t[37], t[33], t[43], t[40], t[29], t[42], t[45], t[41]};
        z[0:8] = inv & {y[15], y[6], x[7], y[16], y[1], y[7], y[11], y[17], y[10]};
        z[9:17] = inv & {y[12], y[3], y[4], y[13], y[5], y[2], y[9], y[14], y[8]};

        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];

        // The inversions fold in the 0x63 affine constant.
        s[0] = t[59] ^ t[63];
        s[6] = ~t[56] ^ t[62];
        s[7] = ~t[48] ^ t[60];
        s[3] = t[53] ^ t[66];
        s[4] = t[51] ^ t[66];
        s[5] = t[47] ^ t[65];
        s[1] = ~t[64] ^ s[3];
        s[2] = ~t[55] ^ t[67];
    end

    always_ff @(posedge clk)
    begin
        out_byte <= s;
    end

endmodule

// ==== hw/cipher_round.sv ====
// One middle AES round over two cycles.
// Registered SubBytes, then ShiftRows, MixColumns and AddRoundKey into the output register.

module cipher_round (
    input  logic               clk,
    input  aes192_pkg::state_t state_in,
    input  aes192_pkg::state_t round_key,
    output aes192_pkg::state_t state_out
);

    localparam int BB = aes192_pkg::BYTE_BITS;

    logic [BB-1:0] sub [16];
    logic [0:3][aes192_pkg::WORD_BITS-1:0] mixed;

    // Multiply by x in GF(2^8).
    function automatic logic [BB-1:0] xtime(input logic [BB-1:0] b);
        xtime = {b[BB-2:0], 1'b0} ^ ({BB{b[BB-1]}} & aes192_pkg::GF_POLY_LOW);
    endfunction

    for (genvar i = 0; i < 16; i++) begin : g_sub
        sbox sbox_inst (
            .clk      (clk),
            .in_byte  (state_in.bytes[i]),
            .out_byte (sub[i])
        );
    end

    for (genvar c = 0; c < 4; c++) begin : g_col
        logic [BB-1:0] a [4];
        logic [BB-1:0] d [4];

        for (genvar r = 0; r < 4; r++) begin : g_row
            assign a[r] = sub[4 * ((c + r) % 4) + r]; // Row r is rotated left by r.
            assign d[r] = xtime(a[r]);
        end

        // 3 times a is d xor a.
        assign mixed[c] = {d[0] ^ d[1] ^ a[1] ^ a[2] ^ a[3],
                           a[0] ^ d[1] ^ d[2] ^ a[2] ^ a[3],
                           a[0] ^ a[1] ^ d[2] ^ d[3] ^ a[3],
                           d[0] ^ a[0] ^ a[1] ^ a[2] ^ d[3]} ^ round_key.cols[c];
    end

    always_ff @(posedge clk)
    begin
        state_out <= mixed;
    end

endmodule

// ==== hw/key_expand_step.sv ====
// One two-cycle step of the AES-192 key schedule.
// The step kind picks which words are renewed and which four form the round key.

module key_expand_step #(
    parameter int                                STEP_KIND = aes192_pkg::STEP_A,
    parameter logic [aes192_pkg::BYTE_BITS-1:0]  RCON = 8'h00
) (
    input  logic                              clk,
    input  logic [aes192_pkg::KEY_BITS-1:0]   key_in,
    output logic [aes192_pkg::KEY_BITS-1:0]   key_out,
    output aes192_pkg::state_t                round_key
);

    localparam int WB = aes192_pkg::WORD_BITS;
    localparam int BB = aes192_pkg::BYTE_BITS;

    // Words that take the SubWord result in the second cycle.
    localparam logic [0:5] SUB_MASK = (STEP_KIND == aes192_pkg::STEP_A) ? 6'b111100 :
                                      (STEP_KIND == aes192_pkg::STEP_B) ? 6'b000000 :
                                                                          6'b110000;

    logic [0:5][WB-1:0] w_in;
    logic [0:5][WB-1:0] w_mid;
    logic [0:5][WB-1:0] w_reg;
    logic [0:5][WB-1:0] w_fin;
    logic [WB-1:0] sub_src;
    logic [WB-1:0] rot_src;
    logic [WB-1:0] sub_word;
    logic [WB-1:0] rcon_word;

    assign w_in = key_in;
    assign rcon_word = {RCON, {(WB - BB){1'b0}}};

    always_comb
    begin
        w_mid = w_in;
        sub_src = w_in[5];
        case (STEP_KIND)
            aes192_pkg::STEP_A:
            begin
                w_mid[0] = w_in[0] ^ rcon_word;
                w_mid[1] = w_mid[0] ^ w_in[1];
                w_mid[2] = w_mid[1] ^ w_in[2];
                w_mid[3] = w_mid[2] ^ w_in[3];
            end
            aes192_pkg::STEP_B:
            begin
                w_mid[2] = w_in[1] ^ w_in[2];
                w_mid[3] = w_mid[2] ^ w_in[3];
                w_mid[4] = w_mid[3] ^ w_in[4];
                w_mid[5] = w_mid[4] ^ w_in[5];
            end
            aes192_pkg::STEP_C:
            begin
                w_mid[4] = w_in[3] ^ w_in[4];
                w_mid[5] = w_mid[4] ^ w_in[5];
                w_mid[0] = w_in[0] ^ rcon_word;
                w_mid[1] = w_mid[0] ^ w_in[1];
                sub_src = w_mid[5]; // SubWord runs on the freshly renewed last word.
            end
            default:
            begin
                w_mid[0] = w_in[0] ^ rcon_word;
                w_mid[1] = w_mid[0] ^ w_in[1];
            end
        endcase
    end

    assign rot_src = {sub_src[WB-BB-1:0], sub_src[WB-1 -: BB]};

    if (STEP_KIND == aes192_pkg::STEP_B) begin : g_no_sub
        assign sub_word = '0;
    end else begin : g_sub
        for (genvar j = 0; j < 4; j++) begin : g_byte
            sbox sbox_inst (
                .clk      (clk),
                .in_byte  (rot_src[WB-1-BB*j -: BB]),
                .out_byte (sub_word[WB-1-BB*j -: BB])
            );
        end
    end

    always_ff @(posedge clk)
    begin
        w_reg <= w_mid; // Lines up with the registered SubWord output.
    end

    always_comb
    begin
        for (int j = 0; j < 6; j++)
            w_fin[j] = SUB_MASK[j] ? (w_reg[j] ^ sub_word) : w_reg[j];
    end

    always_comb
    begin
        case (STEP_KIND)
            aes192_pkg::STEP_A: round_key = {w_fin[0], w_fin[1], w_fin[2], w_fin[3]};
            aes192_pkg::STEP_B: round_key = {w_fin[2], w_fin[3], w_fin[4], w_fin[5]};
            default:            round_key = {w_fin[4], w_fin[5], w_fin[0], w_fin[1]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        key_out <= w_fin;
    end

endmodule

// ==== hw/key_schedule.sv ====
// Chain of twelve AES-192 key steps running beside the data rounds.
// Each step hands one round key to the round that sits at the same depth.

module key_schedule (
    input  logic                              clk,
    input  logic [aes192_pkg::KEY_BITS-1:0]   stage_key,
    output aes192_pkg::state_t                round_keys [aes192_pkg::NUM_ROUNDS]
);

    localparam int N = aes192_pkg::NUM_ROUNDS;

    localparam int STEP_KINDS [N] = '{
        aes192_pkg::STEP_D, aes192_pkg::STEP_B, aes192_pkg::STEP_A, aes192_pkg::STEP_C,
        aes192_pkg::STEP_B, aes192_pkg::STEP_A, aes192_pkg::STEP_C, aes192_pkg::STEP_B,
        aes192_pkg::STEP_A, aes192_pkg::STEP_C, aes192_pkg::STEP_B, aes192_pkg::STEP_A
    };

    // B steps take no round constant.
    localparam logic [aes192_pkg::BYTE_BITS-1:0] STEP_RCONS [N] = '{
        8'h01, 8'h00, 8'h02, 8'h04, 8'h00, 8'h08,
        8'h10, 8'h00, 8'h20, 8'h40, 8'h00, 8'h80
    };

    logic [aes192_pkg::KEY_BITS-1:0] chain [N + 1];

    assign chain[0] = stage_key;

    for (genvar i = 0; i < N; i++) begin : g_step
        key_expand_step #(
            .STEP_KIND (STEP_KINDS[i]),
            .RCON      (STEP_RCONS[i])
        ) key_expand_step_inst (
            .clk       (clk),
            .key_in    (chain[i]),
            .key_out   (chain[i + 1]),
            .round_key (round_keys[i])
        );
    end

endmodule

// ==== hw/input_stage.sv ====
// Input register with the first AddRoundKey and the start of the valid strobe.

module input_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  aes192_pkg::state_t                state,
    input  logic [aes192_pkg::KEY_BITS-1:0]   key,
    input  logic                              in_valid,
    output aes192_pkg::state_t                whitened_state,
    output logic [aes192_pkg::KEY_BITS-1:0]   stage_key,
    output logic                              stage_valid
);

    always_ff @(posedge clk)
    begin
        whitened_state <= state ^ key[aes192_pkg::KEY_BITS-1 -: aes192_pkg::BLOCK_BITS];
        stage_key <= key;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else
            stage_valid <= in_valid;
    end

endmodule

// ==== hw/output_stage.sv ====
// Final AES round without MixColumns, over two cycles.
// Strobe delay line that marks the cycle of valid ciphertext.

module output_stage #(
    parameter int VALID_DELAY = aes192_pkg::PIPE_LATENCY - 1
) (
    input  logic               clk,
    input  logic               reset,
    input  aes192_pkg::state_t state_in,
    input  aes192_pkg::state_t last_key,
    input  logic               stage_valid,
    output aes192_pkg::state_t out,
    output logic               out_valid
);

    localparam int BB = aes192_pkg::BYTE_BITS;

    logic [BB-1:0] sub [16];
    logic [0:3][aes192_pkg::WORD_BITS-1:0] final_cols;
    logic [VALID_DELAY-1:0] valid_pipe;

    for (genvar i = 0; i < 16; i++) begin : g_sub
        sbox sbox_inst (
            .clk      (clk),
            .in_byte  (state_in.bytes[i]),
            .out_byte (sub[i])
        );
    end

    for (genvar c = 0; c < 4; c++) begin : g_col
        assign final_cols[c] = {sub[4 * c], sub[4 * ((c + 1) % 4) + 1],
                                sub[4 * ((c + 2) % 4) + 2], sub[4 * ((c + 3) % 4) + 3]}
                               ^ last_key.cols[c];
    end

    always_ff @(posedge clk)
    begin
        out <= final_cols;
    end

    // Covers the middle rounds plus the two cycles of this stage.
    always_ff @(posedge clk)
    begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[VALID_DELAY-2:0], stage_valid};
    end

    assign out_valid = valid_pipe[VALID_DELAY-1];

endmodule

// ==== hw/aes192_top.sv ====
// Top level of the pipelined AES-192 encryption core.
// Input stage, eleven middle rounds, key schedule and output stage.

module aes192_top (
    input  logic                              clk,
    input  logic                              reset,
    input  aes192_pkg::state_t                state,
    input  logic [aes192_pkg::KEY_BITS-1:0]   key,
    input  logic                              in_valid,
    output aes192_pkg::state_t                out,
    output logic                              out_valid
);

    localparam int N = aes192_pkg::NUM_ROUNDS;

    aes192_pkg::state_t round_state [N];
    aes192_pkg::state_t round_keys [N];
    logic [aes192_pkg::KEY_BITS-1:0] stage_key;
    logic stage_valid;

    input_stage input_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .key            (key),
        .in_valid       (in_valid),
        .whitened_state (round_state[0]),
        .stage_key      (stage_key),
        .stage_valid    (stage_valid)
    );

    key_schedule key_schedule_inst (
        .clk        (clk),
        .stage_key  (stage_key),
        .round_keys (round_keys)
    );

    for (genvar i = 1; i < N; i++) begin : g_round
        cipher_round cipher_round_inst (
            .clk       (clk),
            .state_in  (round_state[i - 1]),
            .round_key (round_keys[i - 1]),
            .state_out (round_state[i])
        );
    end

    output_stage #(
        .VALID_DELAY (aes192_pkg::PIPE_LATENCY - 1)
    ) output_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .state_in    (round_state[N - 1]),
        .last_key    (round_keys[N - 1]),
        .stage_valid (stage_valid),
        .out         (out),
        .out_valid   (out_valid)
    );

endmodule

// ==== verification/aes192_assertions.sv ====
// Concurrent checks on the strobe delay line and the ciphertext of the output stage.

module aes192_assertions (
    input logic               clk,
    input logic               reset,
    input logic               stage_valid,
    input logic               out_valid,
    input aes192_pkg::state_t out
);

    localparam int DELAY = aes192_pkg::PIPE_LATENCY - 1;

    int since_reset;
    int fail_count = 0;

    // Saturates once the delay line holds only post-reset strobes.
    always_ff @(posedge clk)
    begin
        if (reset)
            since_reset <= 0;
        else if (since_reset < DELAY)
            since_reset <= since_reset + 1;
    end

    strobe_delay: assert property (@(posedge clk) disable iff (reset)
        since_reset == DELAY |-> out_valid == $past(stage_valid, DELAY))
    else
    begin
        fail_count++;
        $error("out_valid does not follow stage_valid by %0d cycles", DELAY);
    end

    out_known: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(out))
    else
    begin
        fail_count++;
        $error("out has unknown bits while out_valid is high");
    end

    valid_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else
    begin
        fail_count++;
        $error("out_valid is high in the cycle after reset");
    end

endmodule

bind output_stage aes192_assertions aes192_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .stage_valid (stage_valid),
    .out_valid   (out_valid),
    .out         (out)
);

// ==== verification/aes192_model.svh ====
// Reference AES-192 encryption following FIPS-197, with its S-box table.
// Linear congruential generator for the random stimulus.

`ifndef AES192_MODEL_SVH
`define AES192_MODEL_SVH

// One row of sixteen S-box entries per high nibble.
localparam logic [127:0] SBOX_ROWS [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
};

function automatic logic [7:0] sbox_lookup(input logic [7:0] b);
    return SBOX_ROWS[b[7:4]][127 - 8 * int'(b[3:0]) -: 8];
endfunction

function automatic logic [7:0] xtime_ref(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sbox_lookup(w[31:24]), sbox_lookup(w[23:16]),
            sbox_lookup(w[15:8]), sbox_lookup(w[7:0])};
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [127:0] aes192_encrypt(input logic [127:0] pt,
                                                input logic [191:0] key);
    logic [31:0] w [52];
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [31:0] temp;
    logic [7:0] rc;
    logic [127:0] res;

    // Key expansion with Nk = 6 words.
    rc = 8'h01;
    for (int i = 0; i < 6; i++)
        w[i] = key[191 - 32 * i -: 32];
    for (int i = 6; i < 52; i++)
    begin
        temp = w[i - 1];
        if (i % 6 == 0)
        begin
            temp = sub_word({temp[23:0], temp[31:24]}) ^ {rc, 24'h000000};
            rc = xtime_ref(rc);
        end
        w[i] = w[i - 6] ^ temp;
    end

    for (int k = 0; k < 16; k++)
        s[k] = pt[127 - 8 * k -: 8] ^ w[k / 4][31 - 8 * (k % 4) -: 8];

    for (int rnd = 1; rnd <= aes192_pkg::NUM_ROUNDS; rnd++)
    begin
        // SubBytes and ShiftRows together.
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                t[4 * c + r] = sbox_lookup(s[4 * ((c + r) % 4) + r]);
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                if (rnd < aes192_pkg::NUM_ROUNDS)
                    s[4 * c + r] = xtime_ref(t[4 * c + r])
                                 ^ xtime_ref(t[4 * c + (r + 1) % 4]) ^ t[4 * c + (r + 1) % 4]
                                 ^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
                else
                    s[4 * c + r] = t[4 * c + r]; // Final round has no MixColumns.
        for (int k = 0; k < 16; k++)
            s[k] = s[k] ^ w[4 * rnd + k / 4][31 - 8 * (k % 4) -: 8];
    end

    for (int k = 0; k < 16; k++)
        res[127 - 8 * k -: 8] = s[k];
    return res;
endfunction

`endif

// ==== verification/aes192_tb.sv ====
// Testbench for the pipelined AES-192 core.
// Clock, reset, stimulus, expected-value queue, compare process, watchdog and summary.

module aes192_tb;

    localparam int CLK_PERIOD = 4;
    localparam int LAT = aes192_pkg::PIPE_LATENCY;
    localparam int STIM_CYCLES = 8 + 1 + 200 + 400 + 2 + LAT + 15 + 6 * (LAT + 2);
    localparam int WATCHDOG_CYCLES = (STIM_CYCLES + LAT) * 4;

    logic clk;
    logic reset;
    aes192_pkg::state_t state;
    logic [aes192_pkg::KEY_BITS-1:0] key;
    logic in_valid;
    aes192_pkg::state_t out;
    logic out_valid;

    aes192_pkg::state_t exp_q [$];
    aes192_pkg::state_t last_block;
    logic strobe_hist [$];
    logic [31:0] lcg_state = 32'hb038_030b;
    int checks = 0;
    int errors = 0;
    int blocks_in = 0;
    int blocks_out = 0;

    `include "aes192_model.svh"

    aes192_top aes192_top_inst (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .key       (key),
        .in_valid  (in_valid),
        .out       (out),
        .out_valid (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_block(input string name, input aes192_pkg::state_t expected,
                               input aes192_pkg::state_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_block(input logic v, input aes192_pkg::state_t blk,
                               input logic [aes192_pkg::KEY_BITS-1:0] k);
        state = blk;
        key = k;
        in_valid = v;
        next_cycle();
    endtask

    task automatic random_word(output logic [31:0] w);
        lcg_state = lcg_next(lcg_state);
        w = lcg_state;
    endtask

    task automatic random_input(output aes192_pkg::state_t blk,
                                output logic [aes192_pkg::KEY_BITS-1:0] k);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
        begin
            random_word(w);
            blk.cols[i] = w;
        end
        for (int i = 0; i < 6; i++)
        begin
            random_word(w);
            k[aes192_pkg::KEY_BITS-1-32*i -: 32] = w;
        end
    endtask

    // Waits until every expected block has come out.
    task automatic drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0)
            next_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("test %s: passed", name);
        else
            $display("test %s: failed with %0d errors", name, errors - errors_before);
    endtask

    // Outputs are compared first, then the inputs about to be sampled are recorded.
    always @(negedge clk)
    begin
        if (strobe_hist.size() == LAT)
            check_flag("out_valid", strobe_hist.pop_front(), out_valid);
        if (out_valid === 1'b1)
        begin
            blocks_out++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("error at %0t: out_valid is high but no block was expected", $time);
            end
            else
            begin
                last_block = out;
                check_block("out", exp_q.pop_front(), out);
            end
        end
        if (reset)
        begin
            exp_q.delete();
            foreach (strobe_hist[i])
                strobe_hist[i] = 1'b0; // Reset drops every block in flight.
        end
        strobe_hist.push_back(in_valid && !reset);
        if (in_valid && !reset)
        begin
            exp_q.push_back(aes192_encrypt(state, key));
            blocks_in++;
        end
    end

    initial
    begin
        aes192_pkg::state_t blk;
        logic [aes192_pkg::KEY_BITS-1:0] k;
        logic [31:0] w;
        int err_start;

        clk = 1'b0;
        reset = 1'b1;
        state = '0;
        key = '0;
        in_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        err_start = errors;
        drive_block(1'b1, 128'h00112233445566778899aabbccddeeff,
                    192'h000102030405060708090a0b0c0d0e0f1011121314151617);
        drain();
        check_block("out", 128'hdda97ca4864cdfe06eaf70a0ec0d7191, last_block);
        report_test("fips197 vector", err_start);

        err_start = errors;
        repeat (200)
        begin
            random_input(blk, k);
            drive_block(1'b1, blk, k);
        end
        drain();
        report_test("back-to-back random blocks", err_start);

        err_start = errors;
        repeat (100)
        begin
            random_word(w);
            repeat (int'(w[31:30]))
                drive_block(1'b0, {4{w}} ^ state, key); // Idle cycles still move data.
            random_input(blk, k);
            drive_block(1'b1, blk, k);
        end
        drain();
        report_test("random idle gaps", err_start);

        err_start = errors;
        drive_block(1'b1, '0, '0);
        drive_block(1'b1, '1, '1);
        drain();
        report_test("all-zero and all-one inputs", err_start);

        err_start = errors;
        // Enough blocks that some sit at the output when reset arrives.
        repeat (LAT + 5)
        begin
            random_input(blk, k);
            drive_block(1'b1, blk, k);
        end
        reset = 1'b1;
        repeat (2)
        begin
            random_input(blk, k);
            drive_block(1'b1, blk, k);
        end
        reset = 1'b0;
        repeat (8)
        begin
            random_input(blk, k);
            drive_block(1'b1, blk, k);
        end
        drain();
        report_test("reset with blocks in flight", err_start);

        repeat (LAT + 1) next_cycle();
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected blocks never came out of the pipeline", exp_q.size());
        end
        errors += aes192_top_inst.output_stage_inst.aes192_assertions_inst.fail_count;
        $display("summary: %0d checks, %0d errors, %0d blocks in, %0d blocks out",
                 checks, errors, blocks_in, blocks_out);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verification
hw/aes192_pkg.sv
hw/sbox.sv
hw/cipher_round.sv
hw/key_expand_step.sv
hw/key_schedule.sv
hw/input_stage.sv
hw/output_stage.sv
hw/aes192_top.sv
verification/aes192_assertions.sv
verification/aes192_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the AES-192 testbench with Verilator, then scans sim.log.
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module aes192_tb -f sources.f -o aes192_sim \
    && ./obj_dir/aes192_sim +verilator+error+limit+1000; } > sim.log 2>&1 \
    || echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
